//--- Bender.yml
package:
  name: coco_glue

sources:
  - files:
      - source/coco_glue_pkg.sv
      - source/option_decode.sv
      - source/joystick_router.sv
      - source/config_change_reset.sv
      - source/tape_buffer.sv
      - source/tape_player.sv
      - source/coco_glue_top.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/coco_glue_checker.sv
      - tests/coco_glue_tb.sv

//--- list.f
source/coco_glue_pkg.sv
source/option_decode.sv
source/joystick_router.sv
source/config_change_reset.sv
source/tape_buffer.sv
source/tape_player.sv
source/coco_glue_top.sv
tests/clock_gen.sv
tests/coco_glue_checker.sv
tests/coco_glue_tb.sv

//--- source/coco_glue_pkg.sv
// Shared widths and menu status bit map. Bit positions assume the 64-bit menu status word
`default_nettype none

package coco_glue_pkg;

	// ========================================
	// Widths and typed vectors
	// ========================================
	localparam int STATUS_W = 64;

	typedef logic [STATUS_W-1:0] status_t;
	typedef logic [1:0]          slot_t;
	typedef logic [2:0]          mem_size_t;
	// Digital joystick, bits 4 and 5 are fire buttons
	typedef logic [31:0]         joy_t;
	typedef logic [7:0]          axis_t;
	typedef logic [15:0]         audio_t;
	typedef logic [9:0]          switch_t;

	// ========================================
	// Status bit positions
	// ========================================
	localparam int ST_RESET_BIT = 0;
	localparam int ST_SCALE_LSB = 3;
	localparam int ST_SWAP_JOY  = 6;
	localparam int ST_AR_LSB    = 8;
	localparam int ST_MPI_LSB   = 12;
	localparam int ST_CASS_REC  = 14;
	localparam int ST_REWIND    = 15;
	localparam int ST_CARTINT   = 16;
	localparam int ST_TAPE_MON  = 17;
	localparam int ST_SG6       = 21;
	localparam int ST_COLDBOOT  = 22;
	localparam int ST_MEM_LSB   = 25;
	localparam int ST_TURBO_LSB = 32;
	localparam int ST_ART_LSB   = 37;

	// Download index of a cassette image
	localparam logic [7:0] TAPE_INDEX = 8'd2;

endpackage

`default_nettype wire

//--- source/coco_glue_top.sv
// Single clock domain on clk_sys; status bit 0 acts as an extra synchronous reset for the glue
`timescale 1ns/100ps
`default_nettype none

module coco_glue_top #(
	parameter int TAPE_ADDR_W = 16
) (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire coco_glue_pkg::status_t status,
	input  wire coco_glue_pkg::joy_t    joy1,
	input  wire coco_glue_pkg::joy_t    joy2,
	input  wire [15:0]                 joya1,
	input  wire [15:0]                 joya2,
	input  wire coco_glue_pkg::audio_t  core_audio,
	input  wire                        ioctl_download,
	input  wire                        ioctl_wr,
	input  wire [7:0]                  ioctl_index,
	input  wire [TAPE_ADDR_W-1:0]      ioctl_addr,
	input  wire [7:0]                  ioctl_data,
	input  wire                        cas_relay,
	input  wire                        bit_tick,
	output logic [12:0]                video_arx,
	output logic [12:0]                video_ary,
	output logic [1:0]                 vga_sl,
	output coco_glue_pkg::switch_t     switch_bits,
	output coco_glue_pkg::slot_t       mpi_slot,
	output coco_glue_pkg::mem_size_t   mem_size,
	output logic [2:0]                 turbo_speed,
	output coco_glue_pkg::joy_t        coco_joy1,
	output coco_glue_pkg::joy_t        coco_joy2,
	output logic [15:0]                coco_ajoy1,
	output logic [15:0]                coco_ajoy2,
	output logic [3:0]                 p_switch,
	output logic                       config_reset,
	output logic                       tape_bit,
	output coco_glue_pkg::audio_t      audio_l
);

	// Menu reset joins the board reset
	logic glue_reset;
	logic rewind;
	logic [TAPE_ADDR_W-1:0] rd_addr;
	logic [7:0] rd_data;

	assign glue_reset = reset | status[coco_glue_pkg::ST_RESET_BIT];
	// Loading a new image always starts from the top of the tape
	assign rewind = status[coco_glue_pkg::ST_REWIND] | ioctl_download;

	option_decode u_option_decode (
		.status      (status),
		.core_audio  (core_audio),
		.tape_bit    (tape_bit),
		.video_arx   (video_arx),
		.video_ary   (video_ary),
		.vga_sl      (vga_sl),
		.switch_bits (switch_bits),
		.mpi_slot    (mpi_slot),
		.mem_size    (mem_size),
		.turbo_speed (turbo_speed),
		.audio_l     (audio_l)
	);

	joystick_router u_joystick_router (
		.swap       (status[coco_glue_pkg::ST_SWAP_JOY]),
		.joy1       (joy1),
		.joy2       (joy2),
		.joya1      (joya1),
		.joya2      (joya2),
		.coco_joy1  (coco_joy1),
		.coco_joy2  (coco_joy2),
		.coco_ajoy1 (coco_ajoy1),
		.coco_ajoy2 (coco_ajoy2),
		.p_switch   (p_switch)
	);

	config_change_reset u_config_change_reset (
		.clk_sys      (clk_sys),
		.reset        (glue_reset),
		.mpi_slot     (mpi_slot),
		.mem_size     (mem_size),
		.coldboot     (status[coco_glue_pkg::ST_COLDBOOT]),
		.config_reset (config_reset)
	);

	tape_buffer #(
		.TAPE_ADDR_W (TAPE_ADDR_W)
	) u_tape_buffer (
		.clk_sys        (clk_sys),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data)
	);

	tape_player #(
		.TAPE_ADDR_W (TAPE_ADDR_W)
	) u_tape_player (
		.clk_sys   (clk_sys),
		.reset     (glue_reset),
		.rewind    (rewind),
		.cas_relay (cas_relay),
		.bit_tick  (bit_tick),
		.rd_data   (rd_data),
		.rd_addr   (rd_addr),
		.tape_bit  (tape_bit)
	);

endmodule

`default_nettype wire

//--- source/config_change_reset.sv
// Pulse is one cycle after the sampling edge; first change per field after reset is ignored
`timescale 1ns/100ps
`default_nettype none

module config_change_reset (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire coco_glue_pkg::slot_t      mpi_slot,
	input  wire coco_glue_pkg::mem_size_t  mem_size,
	input  wire                            coldboot,
	output logic                           config_reset
);

	typedef enum logic {
		CHG_FIRST,
		CHG_ARMED
	} chg_state_t;

	chg_state_t slot_state;
	chg_state_t mem_state;
	coco_glue_pkg::slot_t     slot_d;
	coco_glue_pkg::mem_size_t mem_d;
	logic slot_diff;
	logic mem_diff;

	assign slot_diff = (mpi_slot != slot_d);
	assign mem_diff  = (mem_size != mem_d);

	always_ff @(posedge clk_sys)
	begin
		// Delayed copies follow the input so reset release is not seen as a change
		slot_d <= mpi_slot;
		mem_d  <= mem_size;
		if (reset)
		begin
			slot_state   <= CHG_FIRST;
			mem_state    <= CHG_FIRST;
			config_reset <= 1'b0;
		end
		else
		begin
			if (slot_diff)
				slot_state <= CHG_ARMED;
			if (mem_diff)
				mem_state <= CHG_ARMED;
			config_reset <= (slot_diff && (slot_state == CHG_ARMED))
				|| (mem_diff && (mem_state == CHG_ARMED))
				|| coldboot;
		end
	end

endmodule

`default_nettype wire

//--- source/joystick_router.sv
// Combinational joystick routing; analog inputs are signed with Y in the upper byte
`timescale 1ns/100ps
`default_nettype none

module joystick_router (
	input  wire                     swap,
	input  wire coco_glue_pkg::joy_t joy1,
	input  wire coco_glue_pkg::joy_t joy2,
	input  wire [15:0]              joya1,
	input  wire [15:0]              joya2,
	output coco_glue_pkg::joy_t     coco_joy1,
	output coco_glue_pkg::joy_t     coco_joy2,
	output logic [15:0]             coco_ajoy1,
	output logic [15:0]             coco_ajoy2,
	output logic [3:0]              p_switch
);

	coco_glue_pkg::axis_t y1_c;
	coco_glue_pkg::axis_t x1_c;
	coco_glue_pkg::axis_t y2_c;
	coco_glue_pkg::axis_t x2_c;

	// Adding 128 moves a signed axis to an unsigned one centered at 128
	assign y1_c = joya1[15:8] + 8'd128;
	assign x1_c = joya1[7:0] + 8'd128;
	assign y2_c = joya2[15:8] + 8'd128;
	assign x2_c = joya2[7:0] + 8'd128;

	// Swap exchanges whole players, digital and analog together
	assign coco_joy1  = swap ? joy2 : joy1;
	assign coco_joy2  = swap ? joy1 : joy2;
	assign coco_ajoy1 = swap ? {y2_c, x2_c} : {y1_c, x1_c};
	assign coco_ajoy2 = swap ? {y1_c, x1_c} : {y2_c, x2_c};

	// Order R1, L2, R2, L1, active low toward the core
	assign p_switch = ~{coco_joy2[4], coco_joy1[5], coco_joy2[5], coco_joy1[4]};

endmodule

`default_nettype wire

//--- source/option_decode.sv
// Purely combinational menu decode; outputs follow status with no latency
`timescale 1ns/100ps
`default_nettype none

module option_decode (
	input  wire coco_glue_pkg::status_t status,
	input  wire coco_glue_pkg::audio_t  core_audio,
	input  wire                        tape_bit,
	output logic [12:0]                video_arx,
	output logic [12:0]                video_ary,
	output logic [1:0]                 vga_sl,
	output coco_glue_pkg::switch_t     switch_bits,
	output coco_glue_pkg::slot_t       mpi_slot,
	output coco_glue_pkg::mem_size_t   mem_size,
	output logic [2:0]                 turbo_speed,
	output coco_glue_pkg::audio_t      audio_l
);

	logic [1:0] ar;
	logic [2:0] scale;
	logic [2:0] sl_full;
	logic [1:0] art;

	assign ar    = status[coco_glue_pkg::ST_AR_LSB +: 2];
	assign scale = status[coco_glue_pkg::ST_SCALE_LSB +: 3];
	assign art   = status[coco_glue_pkg::ST_ART_LSB +: 2];

	// ========================================
	// Video
	// ========================================
	// Ratio 0 is the original 4:3, others select a scaler preset
	assign video_arx = (ar == 2'd0) ? 13'd4 : ({11'd0, ar} - 13'd1);
	assign video_ary = (ar == 2'd0) ? 13'd3 : 13'd0;

	assign sl_full = (scale == 3'd0) ? 3'd0 : (scale - 3'd1);
	assign vga_sl  = sl_full[1:0];

	// ========================================
	// Core options
	// ========================================
	// Menu slot 0 maps to multi-pak slot 1
	assign mpi_slot    = status[coco_glue_pkg::ST_MPI_LSB +: 2] + 2'd1;
	assign mem_size    = status[coco_glue_pkg::ST_MEM_LSB +: 3];
	assign turbo_speed = status[coco_glue_pkg::ST_TURBO_LSB +: 3];

	assign switch_bits = {
		2'b10,
		art,
		status[coco_glue_pkg::ST_SG6],
		status[coco_glue_pkg::ST_CARTINT],
		status[coco_glue_pkg::ST_CASS_REC],
		mpi_slot,
		1'b0
	};

	// Tape monitor toggles bit 13 of the left channel
	assign audio_l = {
		core_audio[15:14],
		core_audio[13] ^ (status[coco_glue_pkg::ST_TAPE_MON] & tape_bit),
		core_audio[12:0]
	};

endmodule

`default_nettype wire

//--- source/tape_buffer.sv
// Write on the cassette download strobe; read data valid two cycles after rd_addr changes
`timescale 1ns/100ps
`default_nettype none

module tape_buffer #(
	parameter int TAPE_ADDR_W = 16
) (
	input  wire                   clk_sys,
	input  wire                   ioctl_download,
	input  wire                   ioctl_wr,
	input  wire [7:0]             ioctl_index,
	input  wire [TAPE_ADDR_W-1:0] ioctl_addr,
	input  wire [7:0]             ioctl_data,
	input  wire [TAPE_ADDR_W-1:0] rd_addr,
	output logic [7:0]            rd_data
);

	localparam int DEPTH = 1 << TAPE_ADDR_W;

	logic [7:0] mem [0:DEPTH-1];
	logic [TAPE_ADDR_W-1:0] addr_q;
	logic tape_wr;

	// Only cassette images land here
	assign tape_wr = ioctl_download && ioctl_wr
		&& (ioctl_index == coco_glue_pkg::TAPE_INDEX);

	always_ff @(posedge clk_sys)
	begin
		// Download owns the address during a load
		if (ioctl_download)
			addr_q <= ioctl_addr;
		else
			addr_q <= rd_addr;
	end

	always_ff @(posedge clk_sys)
	begin
		if (tape_wr)
			mem[ioctl_addr] <= ioctl_data;
		rd_data <= mem[addr_q];
	end

endmodule

`default_nettype wire

//--- source/tape_player.sv
// Assumes bit ticks at least 4 cycles apart so the 2-cycle buffer read settles between them
`timescale 1ns/100ps
`default_nettype none

module tape_player #(
	parameter int TAPE_ADDR_W = 16
) (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    rewind,
	input  wire                    cas_relay,
	input  wire                    bit_tick,
	input  wire [7:0]              rd_data,
	output logic [TAPE_ADDR_W-1:0] rd_addr,
	output logic                   tape_bit
);

	logic [TAPE_ADDR_W-1:0] byte_ptr;
	logic [2:0] bit_idx;
	logic step;

	// Motor relay gates playback
	assign step    = bit_tick && cas_relay;
	assign rd_addr = byte_ptr;

	// ========================================
	// Byte pointer and bit index
	// ========================================
	always_ff @(posedge clk_sys)
	begin
		if (reset || rewind)
		begin
			byte_ptr <= '0;
			bit_idx  <= 3'd7;
		end
		else if (step)
		begin
			bit_idx <= bit_idx - 3'd1;
			// Wraps at the end of the buffer
			if (bit_idx == 3'd0)
				byte_ptr <= byte_ptr + 1'b1;
		end
	end

	// ========================================
	// Output bit, MSB first
	// ========================================
	// Holds its value across rewind and relay-off ticks
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			tape_bit <= 1'b0;
		else if (step && !rewind)
			tape_bit <= rd_data[bit_idx];
	end

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
// Free-running 4 ns clock; reset stays high for the first 4 rising edges
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
	output logic clk_sys,
	output logic reset
);

	initial
	begin
		clk_sys = 1'b0;
		forever
			#2 clk_sys = ~clk_sys;
	end

	// Released on a falling edge like every other input
	initial
	begin
		reset = 1'b1;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/coco_glue_checker.sv
// Reference tape copy covers addresses 0 to 15 only; playback past byte 15 is not modeled
`timescale 1ns/100ps
`default_nettype none

module coco_glue_checker #(
	parameter int TAPE_ADDR_W = 16
) (
	input wire                           clk_sys,
	input wire                           reset,
	input wire coco_glue_pkg::status_t   status,
	input wire coco_glue_pkg::joy_t      joy1,
	input wire coco_glue_pkg::joy_t      joy2,
	input wire [15:0]                    joya1,
	input wire [15:0]                    joya2,
	input wire coco_glue_pkg::audio_t    core_audio,
	input wire                           ioctl_download,
	input wire                           ioctl_wr,
	input wire [7:0]                     ioctl_index,
	input wire [TAPE_ADDR_W-1:0]         ioctl_addr,
	input wire [7:0]                     ioctl_data,
	input wire                           cas_relay,
	input wire                           bit_tick,
	input wire [12:0]                    video_arx,
	input wire [12:0]                    video_ary,
	input wire [1:0]                     vga_sl,
	input wire coco_glue_pkg::switch_t   switch_bits,
	input wire coco_glue_pkg::slot_t     mpi_slot,
	input wire coco_glue_pkg::mem_size_t mem_size,
	input wire [2:0]                     turbo_speed,
	input wire coco_glue_pkg::joy_t      coco_joy1,
	input wire coco_glue_pkg::joy_t      coco_joy2,
	input wire [15:0]                    coco_ajoy1,
	input wire [15:0]                    coco_ajoy2,
	input wire [3:0]                     p_switch,
	input wire                           config_reset,
	input wire                           tape_bit,
	input wire coco_glue_pkg::audio_t    audio_l
);

	int fail_count = 0;

	logic glue_reset;
	logic rewind;
	logic step;
	logic [1:0] ar;
	logic [2:0] scale;
	coco_glue_pkg::slot_t slot_exp;
	coco_glue_pkg::mem_size_t mem_exp;
	coco_glue_pkg::joy_t p1;
	coco_glue_pkg::joy_t p2;
	logic [7:0] shadow [0:15];
	coco_glue_pkg::slot_t slot_q;
	coco_glue_pkg::mem_size_t mem_q;
	logic slot_seen;
	logic mem_seen;
	logic exp_cfg;
	logic exp_tape;
	int play_ptr;
	int play_bit;

	// Flipping the top bit of each byte is the same as adding 128
	function automatic logic [15:0] centered(input logic [15:0] axes);
		return axes ^ 16'h8080;
	endfunction

	task automatic report_mismatch(input string what);
		$error("FAIL %0t: %s", $time, what);
		fail_count++;
	endtask

	assign glue_reset = reset | status[coco_glue_pkg::ST_RESET_BIT];
	assign rewind     = status[coco_glue_pkg::ST_REWIND] | ioctl_download;
	assign step       = bit_tick & cas_relay;
	assign ar         = status[coco_glue_pkg::ST_AR_LSB +: 2];
	assign scale      = status[coco_glue_pkg::ST_SCALE_LSB +: 3];
	assign slot_exp   = status[coco_glue_pkg::ST_MPI_LSB +: 2] + 2'd1;
	assign mem_exp    = status[coco_glue_pkg::ST_MEM_LSB +: 3];
	assign p1 = status[coco_glue_pkg::ST_SWAP_JOY] ? joy2 : joy1;
	assign p2 = status[coco_glue_pkg::ST_SWAP_JOY] ? joy1 : joy2;

	// ========================================
	// Reference model for reset pulse and tape
	// ========================================
	always @(posedge clk_sys)
	begin
		if (ioctl_download && ioctl_wr && ioctl_index == coco_glue_pkg::TAPE_INDEX
			&& ioctl_addr < 16)
			shadow[ioctl_addr[3:0]] <= ioctl_data;
		slot_q <= slot_exp;
		mem_q  <= mem_exp;
		if (glue_reset)
		begin
			slot_seen <= 1'b0;
			mem_seen  <= 1'b0;
			exp_cfg   <= 1'b0;
			exp_tape  <= 1'b0;
			play_ptr  <= 0;
			play_bit  <= 7;
		end
		else
		begin
			exp_cfg <= status[coco_glue_pkg::ST_COLDBOOT]
				|| (slot_seen && slot_exp != slot_q)
				|| (mem_seen && mem_exp != mem_q);
			if (slot_exp != slot_q)
				slot_seen <= 1'b1;
			if (mem_exp != mem_q)
				mem_seen <= 1'b1;
			if (rewind)
			begin
				play_ptr <= 0;
				play_bit <= 7;
			end
			else if (step)
			begin
				exp_tape <= shadow[play_ptr % 16][play_bit];
				play_bit <= (play_bit == 0) ? 7 : play_bit - 1;
				if (play_bit == 0)
					play_ptr <= play_ptr + 1;
			end
		end
	end

	// ========================================
	// Assertions
	// ========================================
	a_aspect: assert property (@(posedge clk_sys)
		(ar == 2'd0) ? (video_arx == 13'd4 && video_ary == 13'd3)
			: (video_arx == 13'(ar) - 13'd1 && video_ary == 13'd0))
		else report_mismatch("aspect ratio outputs");

	a_scanline: assert property (@(posedge clk_sys)
		vga_sl == ((scale == 3'd0) ? 2'd0 : 2'(scale - 3'd1)))
		else report_mismatch("scanline level");

	a_options: assert property (@(posedge clk_sys)
		mpi_slot == slot_exp && mem_size == mem_exp
			&& turbo_speed == status[coco_glue_pkg::ST_TURBO_LSB +: 3])
		else report_mismatch("slot, memory size or turbo");

	a_switches: assert property (@(posedge clk_sys)
		switch_bits == {2'b10, status[coco_glue_pkg::ST_ART_LSB +: 2],
			status[coco_glue_pkg::ST_SG6], status[coco_glue_pkg::ST_CARTINT],
			status[coco_glue_pkg::ST_CASS_REC], slot_exp, 1'b0})
		else report_mismatch("switch vector layout");

	a_digital: assert property (@(posedge clk_sys)
		coco_joy1 == p1 && coco_joy2 == p2)
		else report_mismatch("digital joystick routing");

	a_analog: assert property (@(posedge clk_sys)
		status[coco_glue_pkg::ST_SWAP_JOY]
			? (coco_ajoy1 == centered(joya2) && coco_ajoy2 == centered(joya1))
			: (coco_ajoy1 == centered(joya1) && coco_ajoy2 == centered(joya2)))
		else report_mismatch("analog axis centering or routing");

	a_buttons: assert property (@(posedge clk_sys)
		p_switch == ~{p2[4], p1[5], p2[5], p1[4]})
		else report_mismatch("fire button vector");

	a_audio: assert property (@(posedge clk_sys)
		audio_l == (core_audio ^ (16'(status[coco_glue_pkg::ST_TAPE_MON] & tape_bit) << 13)))
		else report_mismatch("tape monitor audio");

	a_config: assert property (@(posedge clk_sys) disable iff (reset)
		config_reset == exp_cfg)
		else report_mismatch("config reset pulse");

	a_tape: assert property (@(posedge clk_sys) disable iff (reset)
		tape_bit == exp_tape)
		else report_mismatch("tape playback bit");

endmodule

`default_nettype wire

//--- tests/coco_glue_tb.sv
// Drives the glue on falling edges; ticks are 5 cycles apart to cover the buffer read latency
`timescale 1ns/100ps
`default_nettype none

module coco_glue_tb;

	// Stimulus takes about 1000 cycles
	localparam int TIMEOUT_CYCLES = 6000;
	localparam int TICK_GAP = 5;
	localparam int TAPE_ADDR_W = 16;

	logic clk_sys;
	logic reset;
	coco_glue_pkg::status_t status;
	coco_glue_pkg::joy_t joy1;
	coco_glue_pkg::joy_t joy2;
	logic [15:0] joya1;
	logic [15:0] joya2;
	coco_glue_pkg::audio_t core_audio;
	logic ioctl_download;
	logic ioctl_wr;
	logic [7:0] ioctl_index;
	logic [TAPE_ADDR_W-1:0] ioctl_addr;
	logic [7:0] ioctl_data;
	logic cas_relay;
	logic bit_tick;
	logic [12:0] video_arx;
	logic [12:0] video_ary;
	logic [1:0] vga_sl;
	coco_glue_pkg::switch_t switch_bits;
	coco_glue_pkg::slot_t mpi_slot;
	coco_glue_pkg::mem_size_t mem_size;
	logic [2:0] turbo_speed;
	coco_glue_pkg::joy_t coco_joy1;
	coco_glue_pkg::joy_t coco_joy2;
	logic [15:0] coco_ajoy1;
	logic [15:0] coco_ajoy2;
	logic [3:0] p_switch;
	logic config_reset;
	logic tape_bit;
	coco_glue_pkg::audio_t audio_l;
	logic [31:0] rng;
	int cycles = 0;

	clock_gen u_clock_gen (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	coco_glue_top #(
		.TAPE_ADDR_W (TAPE_ADDR_W)
	) u_coco_glue_top (.*);

	bind coco_glue_top coco_glue_checker #(
		.TAPE_ADDR_W (TAPE_ADDR_W)
	) u_coco_glue_checker (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped");
	endtask

	// ========================================
	// Stimulus
	// ========================================
	// First change of each field arms it, the second one pulses
	task automatic change_config();
		status[coco_glue_pkg::ST_MPI_LSB +: 2] = 2'd1;
		repeat (3) @(negedge clk_sys);
		status[coco_glue_pkg::ST_MPI_LSB +: 2] = 2'd2;
		repeat (3) @(negedge clk_sys);
		status[coco_glue_pkg::ST_MEM_LSB +: 3] = 3'd1;
		repeat (3) @(negedge clk_sys);
		status[coco_glue_pkg::ST_MEM_LSB +: 3] = 3'd4;
		repeat (3) @(negedge clk_sys);
		status[coco_glue_pkg::ST_COLDBOOT] = 1'b1;
		@(negedge clk_sys);
		status[coco_glue_pkg::ST_COLDBOOT] = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic sweep_video_options();
		for (int ar = 0; ar < 4; ar++)
		begin
			for (int sc = 0; sc < 8; sc++)
			begin
				rng = xorshift(rng);
				status[63:32] = rng;
				rng = xorshift(rng);
				status[31:0] = rng;
				status[coco_glue_pkg::ST_RESET_BIT] = 1'b0;
				status[coco_glue_pkg::ST_AR_LSB +: 2] = 2'(ar);
				status[coco_glue_pkg::ST_SCALE_LSB +: 3] = 3'(sc);
				core_audio = rng[31:16];
				@(negedge clk_sys);
			end
		end
		status = '0;
		@(negedge clk_sys);
	endtask

	task automatic route_joysticks();
		for (int i = 0; i < 32; i++)
		begin
			rng = xorshift(rng);
			joy1 = rng;
			rng = xorshift(rng);
			joy2 = rng;
			rng = xorshift(rng);
			joya1 = rng[15:0];
			joya2 = rng[31:16];
			status[coco_glue_pkg::ST_SWAP_JOY] = i[0];
			@(negedge clk_sys);
		end
	endtask

	task automatic load_tape();
		ioctl_download = 1'b1;
		ioctl_index = coco_glue_pkg::TAPE_INDEX;
		for (int a = 0; a < 16; a++)
		begin
			rng = xorshift(rng);
			ioctl_addr = TAPE_ADDR_W'(a);
			ioctl_data = rng[7:0];
			ioctl_wr = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			@(negedge clk_sys);
		end
		// Strobe for a different image index must not reach the tape
		ioctl_index = 8'd1;
		ioctl_addr = TAPE_ADDR_W'(3);
		ioctl_data = ~rng[15:8];
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic play_tape(input int ticks);
		for (int t = 0; t < ticks; t++)
		begin
			rng = xorshift(rng);
			core_audio = rng[15:0];
			bit_tick = 1'b1;
			@(negedge clk_sys);
			bit_tick = 1'b0;
			repeat (TICK_GAP - 1) @(negedge clk_sys);
		end
	endtask

	task automatic rewind_tape();
		status[coco_glue_pkg::ST_REWIND] = 1'b1;
		@(negedge clk_sys);
		status[coco_glue_pkg::ST_REWIND] = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	always @(posedge clk_sys)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			stop_with_failure("Timeout: stimulus did not finish within the cycle limit");
	end

	always @(negedge clk_sys)
	begin
		if (u_coco_glue_top.u_coco_glue_checker.fail_count != 0)
			stop_with_failure("A checker assertion failed");
	end

	initial
	begin
		status = '0;
		joy1 = '0;
		joy2 = '0;
		joya1 = '0;
		joya2 = '0;
		core_audio = '0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_data = '0;
		cas_relay = 1'b0;
		bit_tick = 1'b0;
		rng = 32'h840f4e78;
		@(negedge reset);
		change_config();
		sweep_video_options();
		route_joysticks();
		load_tape();
		status[coco_glue_pkg::ST_TAPE_MON] = 1'b1;
		cas_relay = 1'b1;
		play_tape(60);
		// Relay drops in the middle of a byte
		cas_relay = 1'b0;
		play_tape(4);
		cas_relay = 1'b1;
		play_tape(68);
		// Rewind at a byte boundary and again mid-byte
		rewind_tape();
		play_tape(20);
		rewind_tape();
		play_tape(20);
		repeat (3) @(negedge clk_sys);
		if (u_coco_glue_top.u_coco_glue_checker.fail_count != 0)
			stop_with_failure("A checker assertion failed");
		else
		begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire
